//--- source/lsuPkg.sv
package lsuPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths with a meaning
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] wordT;      // Data word, CPU side and bus side
  typedef logic [31:0] addrT;      // Physical byte address
  typedef logic [3:0]  byteMaskT;  // One strobe bit per byte lane
  typedef logic [2:0]  funct3T;    // Size in [1:0], unsigned load in [2]
  typedef logic [1:0]  memRwT;     // Request type from the memory stage
  typedef logic [1:0]  htransT;    // AHB transfer type
  typedef logic [2:0]  hsizeT;     // AHB transfer size

  // Request encodings
  localparam memRwT memNone  = 2'b00;
  localparam memRwT memRead  = 2'b10;
  localparam memRwT memWrite = 2'b01;

  // Access size, low bits of funct3
  localparam logic [1:0] sizeByte = 2'b00;
  localparam logic [1:0] sizeHalf = 2'b01;

  localparam htransT htransIdle   = 2'b00;  // No transfer this cycle
  localparam htransT htransNonseq = 2'b10;  // Single transfer

  localparam int timeoutW = 8;  // Wait counter width

  // Bus controller states
  typedef enum logic [1:0] {
    Idle,  // Waiting for a request, drives the address phase
    Data,  // Data phase, waiting for HREADY
    Done   // One cycle to retire the access
  } busStateT;

  // Reverse byte order of a word in big-endian mode
  function automatic wordT swapBytes(input wordT w, input logic bigEndian);
    wordT swapped;
    swapped = {w[7:0], w[15:8], w[23:16], w[31:24]};
    return bigEndian ? swapped : w;
  endfunction

endpackage

//--- source/busCtrl.sv
module busCtrl (
  input  logic           clk,
  input  logic           rst,
  input  lsuPkg::memRwT  MemRWM,                    // Read/write request
  input  lsuPkg::funct3T Funct3M,                   // Access size
  input  lsuPkg::addrT   IEUAdrM,                   // Request address
  input  logic           LSUHREADY,                 // Slave ready
  input  logic           timedOut,                  // Wait limit reached
  output lsuPkg::addrT   LSUHADDR,
  output lsuPkg::htransT LSUHTRANS,
  output logic           LSUHWRITE,
  output lsuPkg::hsizeT  LSUHSIZE,
  output logic           LSUStallM,                 // Hold the pipeline
  output logic           startXfer,                 // Address phase accepted
  output logic           inData,                    // Data phase in progress
  output logic           captureEn,                 // Grab HRDATA this edge
  output logic           doneCycle,                 // Load completed, update ReadDataW
  output logic           LoadMisalignedFaultM,
  output logic           StoreAmoMisalignedFaultM,
  output logic           LoadAccessFaultM,
  output logic           StoreAmoAccessFaultM
);
  import lsuPkg::*;

  busStateT state, nextState;
  logic     request;      // Any load or store presented
  logic     misaligned;   // Address not a multiple of the size
  logic     goReq;        // Aligned request seen in Idle
  logic     isDone;
  logic     isWrite;      // Transfer in flight is a store
  logic     timeoutSeen;  // Transfer was ended by the wait timer

  //////////////////////////////////////////////////////////////////////
  // Request decode and misalignment
  //////////////////////////////////////////////////////////////////////

  assign request = (MemRWM != memNone);

  always_comb begin
    case (Funct3M[1:0])
      sizeByte: misaligned = 1'b0;                      // Bytes always fit
      sizeHalf: misaligned = IEUAdrM[0];
      default:  misaligned = (IEUAdrM[1:0] != 2'b00);   // Word
    endcase
  end

  assign goReq = (state == Idle) & request & ~misaligned;

  // Misaligned requests fault in place and never reach the bus
  assign LoadMisalignedFaultM     = (state == Idle) & misaligned & (MemRWM == memRead);
  assign StoreAmoMisalignedFaultM = (state == Idle) & misaligned & (MemRWM == memWrite);

  // Address phase straight from the CPU request
  assign LSUHADDR  = IEUAdrM;
  assign LSUHWRITE = (MemRWM == memWrite);
  assign LSUHSIZE  = {1'b0, Funct3M[1:0]};
  assign LSUHTRANS = goReq ? htransNonseq : htransIdle;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      Idle:    if (goReq && LSUHREADY) nextState = Data;
      Data:    if (LSUHREADY || timedOut) nextState = Done;  // Ready wins over timeout
      Done:    nextState = Idle;
      default: nextState = Idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= Idle;
      isWrite     <= 1'b0;
      timeoutSeen <= 1'b0;
    end else begin
      state <= nextState;
      if (startXfer) isWrite <= LSUHWRITE;  // Remember direction for Done
      if (inData) timeoutSeen <= ~LSUHREADY & timedOut;
    end
  end

  assign isDone    = (state == Done);
  assign inData    = (state == Data);
  assign startXfer = goReq & LSUHREADY;
  assign LSUStallM = goReq | inData;  // Released in Done
  assign captureEn = inData & LSUHREADY & ~isWrite;
  assign doneCycle = isDone & ~isWrite & ~timeoutSeen;

  // Access faults only for transfers the timer ended
  assign LoadAccessFaultM     = isDone & timeoutSeen & ~isWrite;
  assign StoreAmoAccessFaultM = isDone & timeoutSeen & isWrite;

endmodule

//--- source/waitTimer.sv
module waitTimer #(
  parameter int TimeoutCycles = 20  // Wait cycles allowed before a fault
) (
  input  logic clk,
  input  logic rst,
  input  logic startXfer,   // New transfer, restart the count
  input  logic inData,      // Data phase in progress
  input  logic LSUHREADY,   // Slave ready
  output logic timedOut     // Limit reached
);
  import lsuPkg::*;

  localparam logic [timeoutW-1:0] waitLimit = timeoutW'(TimeoutCycles);

  logic [timeoutW-1:0] waitCount;  // Data phase cycles with HREADY low
  logic                saturated;
  logic                waitCycle;

  assign saturated = (waitCount == '1);     // Never wraps back to zero
  assign waitCycle = inData & ~LSUHREADY;

  //////////////////////////////////////////////////////////////////////
  // Wait counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      waitCount <= '0;
    end else if (startXfer) begin
      waitCount <= '0;                       // Address phase clears
    end else if (waitCycle && !saturated) begin
      waitCount <= waitCount + 1'b1;
    end
  end

  // Combinational so the FSM can leave Data in the same cycle
  assign timedOut = (waitCount >= waitLimit);

endmodule

//--- source/storeFormat.sv
module storeFormat (
  input  lsuPkg::wordT     WriteDataM,  // Store data from the integer unit
  input  lsuPkg::funct3T   Funct3M,     // Access size
  input  lsuPkg::addrT     IEUAdrM,     // Byte address
  input  logic             BigEndianM,  // Memory is big-endian
  output lsuPkg::wordT     LSUHWDATA,   // Bus write data
  output lsuPkg::byteMaskT LSUHWSTRB    // Bus byte strobes
);
  import lsuPkg::*;

  wordT       replData;  // Subword copied into every lane
  byteMaskT   leMask;    // Strobe in little-endian lane order
  byteMaskT   beMask;    // Same strobe, lanes mirrored
  logic [1:0] offset;    // Byte offset within the word

  assign offset = IEUAdrM[1:0];

  //////////////////////////////////////////////////////////////////////
  // Write data
  //////////////////////////////////////////////////////////////////////

  // Replicate so the subword lands on its lane whatever the offset
  always_comb begin
    case (Funct3M[1:0])
      sizeByte: replData = {4{WriteDataM[7:0]}};
      sizeHalf: replData = {2{WriteDataM[15:0]}};
      default:  replData = WriteDataM;
    endcase
  end

  assign LSUHWDATA = swapBytes(replData, BigEndianM);

  //////////////////////////////////////////////////////////////////////
  // Byte strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (Funct3M[1:0])
      sizeByte: leMask = byteMaskT'(4'b0001 << offset);  // One lane
      sizeHalf: leMask = offset[1] ? 4'b1100 : 4'b0011;  // Upper or lower pair
      default:  leMask = 4'b1111;
    endcase
  end

  // Mirror the lanes to follow the swapped data
  assign beMask = {leMask[0], leMask[1], leMask[2], leMask[3]};

  assign LSUHWSTRB = BigEndianM ? beMask : leMask;

endmodule

//--- source/loadFormat.sv
module loadFormat (
  input  logic           clk,
  input  logic           rst,
  input  lsuPkg::wordT   HRDATA,      // Bus read data
  input  logic           captureEn,   // Data phase completes this edge
  input  logic           doneCycle,   // Retire the load this edge
  input  lsuPkg::funct3T Funct3M,     // Size and sign of the load
  input  lsuPkg::addrT   IEUAdrM,     // Byte address
  input  logic           BigEndianM,  // Memory is big-endian
  output lsuPkg::wordT   ReadDataW    // Result to writeback
);
  import lsuPkg::*;

  wordT        busWord;     // HRDATA held past the data phase
  wordT        leWord;      // Word in little-endian byte order
  logic [7:0]  byteSel;     // Addressed byte
  logic [15:0] halfSel;     // Addressed halfword
  logic        byteSign;    // Fill bit for byte loads
  logic        halfSign;    // Fill bit for halfword loads
  wordT        readDataM;   // Extended result, memory stage

  //////////////////////////////////////////////////////////////////////
  // Capture and byte order
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (captureEn) busWord <= HRDATA;
  end

  assign leWord = swapBytes(busWord, BigEndianM);

  //////////////////////////////////////////////////////////////////////
  // Subword select and extend
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (IEUAdrM[1:0])
      2'b00:   byteSel = leWord[7:0];
      2'b01:   byteSel = leWord[15:8];
      2'b10:   byteSel = leWord[23:16];
      default: byteSel = leWord[31:24];
    endcase
  end

  assign halfSel = IEUAdrM[1] ? leWord[31:16] : leWord[15:0];  // Aligned halves only

  // Funct3M[2] set means zero-extend
  assign byteSign = ~Funct3M[2] & byteSel[7];
  assign halfSign = ~Funct3M[2] & halfSel[15];

  always_comb begin
    case (Funct3M[1:0])
      sizeByte: readDataM = {{24{byteSign}}, byteSel};
      sizeHalf: readDataM = {{16{halfSign}}, halfSel};
      default:  readDataM = leWord;
    endcase
  end

  // Writeback register, left alone on stores and timeouts
  always_ff @(posedge clk) begin
    if (rst) begin
      ReadDataW <= '0;
    end else if (doneCycle) begin
      ReadDataW <= readDataM;
    end
  end

endmodule

//--- source/lsu.sv
module lsu #(
  parameter int TimeoutCycles = 20  // Bus wait limit before an access fault
) (
  input  logic             clk,
  input  logic             rst,
  // CPU request, held while stalled
  input  lsuPkg::memRwT    MemRWM,
  input  lsuPkg::funct3T   Funct3M,
  input  lsuPkg::addrT     IEUAdrM,
  input  lsuPkg::wordT     WriteDataM,
  input  logic             BigEndianM,
  output logic             LSUStallM,                 // Transfer in flight
  output lsuPkg::wordT     ReadDataW,                 // Load result
  // Faults
  output logic             LoadMisalignedFaultM,
  output logic             StoreAmoMisalignedFaultM,
  output logic             LoadAccessFaultM,          // Load timed out on the bus
  output logic             StoreAmoAccessFaultM,      // Store timed out on the bus
  // AHB-lite side
  input  lsuPkg::wordT     HRDATA,
  input  logic             LSUHREADY,
  output lsuPkg::addrT     LSUHADDR,
  output lsuPkg::htransT   LSUHTRANS,
  output logic             LSUHWRITE,
  output lsuPkg::hsizeT    LSUHSIZE,
  output lsuPkg::wordT     LSUHWDATA,
  output lsuPkg::byteMaskT LSUHWSTRB
);

  logic startXfer;  // Address phase accepted
  logic inData;     // Data phase in progress
  logic timedOut;   // Wait limit reached
  logic captureEn;  // Load data on the bus this edge
  logic doneCycle;  // Load retires this edge

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  busCtrl ctrl (
    .clk, .rst, .MemRWM, .Funct3M, .IEUAdrM, .LSUHREADY, .timedOut,
    .LSUHADDR, .LSUHTRANS, .LSUHWRITE, .LSUHSIZE, .LSUStallM,
    .startXfer, .inData, .captureEn, .doneCycle,
    .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM,
    .LoadAccessFaultM, .StoreAmoAccessFaultM
  );

  waitTimer #(.TimeoutCycles(TimeoutCycles)) timer (
    .clk, .rst, .startXfer, .inData, .LSUHREADY, .timedOut
  );

  //////////////////////////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////////////////////////

  // Store side is combinational, CPU holds the inputs through the data phase
  storeFormat storeFmt (
    .WriteDataM, .Funct3M, .IEUAdrM, .BigEndianM, .LSUHWDATA, .LSUHWSTRB
  );

  loadFormat loadFmt (
    .clk, .rst, .HRDATA, .captureEn, .doneCycle,
    .Funct3M, .IEUAdrM, .BigEndianM, .ReadDataW
  );

endmodule

//--- tb/memSlave.sv
module memSlave (
  input  logic             clk,
  input  logic             rst,
  input  lsuPkg::addrT     HADDR,
  input  lsuPkg::htransT   HTRANS,
  input  logic             HWRITE,
  input  lsuPkg::wordT     HWDATA,
  input  lsuPkg::byteMaskT HWSTRB,
  input  logic [7:0]       waitCycles,  // Wait states for the next transfer
  input  logic             stuck,       // Never finish the next transfer
  output lsuPkg::wordT     HRDATA,
  output logic             HREADY
);
  timeunit 1ns;
  timeprecision 100ps;
  import lsuPkg::*;

  wordT       mem [0:15];  // 64 bytes, wraps above
  logic       dataPhase;   // Transfer accepted, not yet finished
  logic       stuckXfer;   // Current transfer hangs
  logic       writeXfer;
  logic [3:0] wordIdx;     // Word address latched in the address phase
  logic [7:0] waitLeft;

  assign HREADY = !dataPhase || (!stuckXfer && waitLeft == 8'd0);
  assign HRDATA = mem[wordIdx];  // Valid through the data phase

  always @(posedge clk) begin
    if (rst) begin
      // Every byte distinct, derived from its own address
      for (int i = 0; i < 16; i++) begin
        mem[i] <= {8'(4 * i + 3), 8'(4 * i + 2), 8'(4 * i + 1), 8'(4 * i)} ^ 32'h5ac3a55c;
      end
      dataPhase <= 1'b0;
      stuckXfer <= 1'b0;
      writeXfer <= 1'b0;
      wordIdx   <= '0;
      waitLeft  <= '0;
    end else begin
      if (dataPhase && HREADY) begin
        dataPhase <= 1'b0;
        if (writeXfer) begin
          for (int b = 0; b < 4; b++) begin
            if (HWSTRB[b]) mem[wordIdx][b * 8 +: 8] <= HWDATA[b * 8 +: 8];
          end
        end
      end else if (dataPhase && stuckXfer && !stuck) begin
        dataPhase <= 1'b0;  // Master gave up, drop it without a write
      end else if (dataPhase && !stuckXfer) begin
        waitLeft <= waitLeft - 8'd1;
      end
      // Address phase
      if (HTRANS == htransNonseq && HREADY) begin
        dataPhase <= 1'b1;
        stuckXfer <= stuck;
        writeXfer <= HWRITE;
        wordIdx   <= HADDR[5:2];
        waitLeft  <= waitCycles;
      end
    end
  end

endmodule

//--- tb/lsuTb.sv
module lsuTb;
  timeunit 1ns;
  timeprecision 100ps;
  import lsuPkg::*;

  localparam int TimeoutCycles = 20;
  localparam int resetCycles   = 16;
  localparam logic [7:0] randW = 8'hff;  // Wait count picked at random
  // funct3 values
  localparam funct3T szB  = 3'b000;
  localparam funct3T szH  = 3'b001;
  localparam funct3T szW  = 3'b010;
  localparam funct3T szBU = 3'b100;
  localparam funct3T szHU = 3'b101;

  typedef struct packed {
    memRwT      rw;
    funct3T     f3;
    addrT       adr;
    wordT       wdata;
    logic       be;     // Big-endian
    logic [7:0] waits;  // Slave wait states
    logic       stuck;  // Slave never answers
  } rowT;

  logic clk, rst, BigEndianM, LSUHREADY, LSUStallM, LSUHWRITE, stuck;
  logic LoadMisalignedFaultM, StoreAmoMisalignedFaultM;
  logic LoadAccessFaultM, StoreAmoAccessFaultM;
  memRwT    MemRWM;
  funct3T   Funct3M;
  addrT     IEUAdrM, LSUHADDR;
  wordT     WriteDataM, ReadDataW, HRDATA, LSUHWDATA;
  htransT   LSUHTRANS;
  hsizeT    LSUHSIZE;
  byteMaskT LSUHWSTRB;
  logic [7:0] waitCycles;

  rowT  stim [$];
  wordT shadow [0:15];  // Expected memory in bus lane order
  wordT lastRead;       // Expected ReadDataW
  int   cycleCount = 0;
  int   cycleLimit = 0;

  lsu #(.TimeoutCycles(TimeoutCycles)) dut (
    .clk, .rst, .MemRWM, .Funct3M, .IEUAdrM, .WriteDataM, .BigEndianM,
    .LSUStallM, .ReadDataW, .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM,
    .LoadAccessFaultM, .StoreAmoAccessFaultM, .HRDATA, .LSUHREADY,
    .LSUHADDR, .LSUHTRANS, .LSUHWRITE, .LSUHSIZE, .LSUHWDATA, .LSUHWSTRB
  );

  memSlave slave (
    .clk, .rst, .HADDR(LSUHADDR), .HTRANS(LSUHTRANS), .HWRITE(LSUHWRITE),
    .HWDATA(LSUHWDATA), .HWSTRB(LSUHWSTRB), .waitCycles, .stuck,
    .HRDATA, .HREADY(LSUHREADY)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      abortRun($sformatf("Timeout, the DUT did not finish within %0d cycles", cycleLimit));
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkWord(input wordT got, input wordT exp, input string what);
    if (got !== exp) abortRun($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                        $time, what, got, exp));
  endtask

  task automatic checkAddr(input addrT got, input addrT exp, input string what);
    if (got !== exp) abortRun($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                        $time, what, got, exp));
  endtask

  task automatic checkSize(input hsizeT got, input hsizeT exp, input string what);
    if (got !== exp) abortRun($sformatf("Mismatch at %0t ns: %s got %0d expected %0d",
                                        $time, what, got, exp));
  endtask

  task automatic checkMask(input byteMaskT got, input byteMaskT exp, input string what);
    if (got !== exp) abortRun($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                        $time, what, got, exp));
  endtask

  task automatic checkFault(input logic got, input logic exp, input string what);
    if (got !== exp) abortRun($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                        $time, what, got, exp));
  endtask

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  function automatic wordT fillWord(input int i);
    return {8'(4 * i + 3), 8'(4 * i + 2), 8'(4 * i + 1), 8'(4 * i)} ^ 32'h5ac3a55c;
  endfunction

  function automatic int sizeBytes(input funct3T f);
    case (f[1:0])
      2'b00:   return 1;
      2'b01:   return 2;
      default: return 4;
    endcase
  endfunction

  // AHB size code is log2 of the byte count
  function automatic hsizeT busSize(input int n);
    case (n)
      1:       return 3'd0;
      2:       return 3'd1;
      default: return 3'd2;
    endcase
  endfunction

  // Big-endian mode mirrors the bus lane of a byte address
  function automatic logic [1:0] laneOf(input addrT a, input logic be);
    return be ? ~a[1:0] : a[1:0];
  endfunction

  function automatic byteMaskT strobeFor(input addrT a, input int n, input logic be);
    byteMaskT m;
    m = '0;
    for (int k = 0; k < n; k++) m[laneOf(a + addrT'(k), be)] = 1'b1;
    return m;
  endfunction

  // Data byte k goes to address adr + k
  task automatic storeShadow(input rowT r);
    addrT a;
    for (int k = 0; k < sizeBytes(r.f3); k++) begin
      a = r.adr + addrT'(k);
      shadow[a[5:2]][int'(laneOf(a, r.be)) * 8 +: 8] = r.wdata[k * 8 +: 8];
    end
  endtask

  function automatic wordT loadExpect(input rowT r);
    wordT v;
    addrT a;
    int   n;
    logic fill;
    n = sizeBytes(r.f3);
    v = '0;
    for (int k = 0; k < n; k++) begin
      a = r.adr + addrT'(k);
      v[k * 8 +: 8] = shadow[a[5:2]][int'(laneOf(a, r.be)) * 8 +: 8];
    end
    fill = ~r.f3[2] & v[n * 8 - 1];  // Sign bit unless unsigned
    for (int k = n; k < 4; k++) v[k * 8 +: 8] = {8{fill}};
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  task automatic fillTable();
    // Little-endian word store and load
    stim.push_back(rowT'{memWrite, szW, 32'h10, 32'hcafef00d, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memRead, szW, 32'h10, 32'h0, 1'b0, randW, 1'b0});
    // Subword stores on every lane, then whole words
    stim.push_back(rowT'{memWrite, szB, 32'h21, 32'h123456a1, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memWrite, szB, 32'h23, 32'h000000b2, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memWrite, szB, 32'h24, 32'hffffffc3, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memWrite, szB, 32'h26, 32'h000000d4, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memWrite, szH, 32'h28, 32'h9999beef, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memWrite, szH, 32'h2e, 32'h00001234, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memRead, szW, 32'h20, 32'h0, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memRead, szW, 32'h24, 32'h0, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memRead, szW, 32'h28, 32'h0, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memRead, szW, 32'h2c, 32'h0, 1'b0, randW, 1'b0});
    // Sign and zero extension
    stim.push_back(rowT'{memRead, szB, 32'h13, 32'h0, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memRead, szBU, 32'h13, 32'h0, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memRead, szH, 32'h12, 32'h0, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memRead, szHU, 32'h12, 32'h0, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memRead, szH, 32'h2e, 32'h0, 1'b0, randW, 1'b0});
    // Big-endian
    stim.push_back(rowT'{memWrite, szW, 32'h18, 32'h11223344, 1'b1, randW, 1'b0});
    stim.push_back(rowT'{memRead, szW, 32'h18, 32'h0, 1'b1, randW, 1'b0});
    stim.push_back(rowT'{memRead, szW, 32'h18, 32'h0, 1'b0, randW, 1'b0});
    stim.push_back(rowT'{memWrite, szB, 32'h19, 32'h000000ee, 1'b1, randW, 1'b0});
    stim.push_back(rowT'{memRead, szB, 32'h19, 32'h0, 1'b1, randW, 1'b0});
    stim.push_back(rowT'{memWrite, szH, 32'h1a, 32'h0000a566, 1'b1, randW, 1'b0});
    stim.push_back(rowT'{memRead, szHU, 32'h1a, 32'h0, 1'b1, randW, 1'b0});
    // Misaligned requests never reach the bus
    stim.push_back(rowT'{memRead, szH, 32'h11, 32'h0, 1'b0, 8'd0, 1'b0});
    stim.push_back(rowT'{memRead, szW, 32'h12, 32'h0, 1'b0, 8'd0, 1'b0});
    stim.push_back(rowT'{memWrite, szH, 32'h13, 32'h5555, 1'b0, 8'd0, 1'b0});
    stim.push_back(rowT'{memWrite, szW, 32'h16, 32'h6666, 1'b0, 8'd0, 1'b0});
    // Stuck slave, then a long wait just under the limit
    stim.push_back(rowT'{memRead, szW, 32'h10, 32'h0, 1'b0, 8'(TimeoutCycles), 1'b1});
    stim.push_back(rowT'{memWrite, szW, 32'h10, 32'hdeadbeef, 1'b0, 8'(TimeoutCycles), 1'b1});
    stim.push_back(rowT'{memRead, szW, 32'h10, 32'h0, 1'b0, 8'(TimeoutCycles - 1), 1'b0});
  endtask

  task automatic runRow(input rowT r);
    int       n;
    logic     misal;
    byteMaskT expStrobe;
    n = sizeBytes(r.f3);
    misal = (int'(r.adr[1:0]) % n) != 0;
    expStrobe = strobeFor(r.adr, n, r.be);
    @(posedge clk);
    #1;
    MemRWM     = r.rw;
    Funct3M    = r.f3;
    IEUAdrM    = r.adr;
    WriteDataM = r.wdata;
    BigEndianM = r.be;
    waitCycles = r.waits;
    stuck      = r.stuck;
    @(negedge clk);
    if (misal) begin
      checkFault(LoadMisalignedFaultM, r.rw == memRead, "load misaligned fault");
      checkFault(StoreAmoMisalignedFaultM, r.rw == memWrite, "store misaligned fault");
      checkFault(LSUStallM, 1'b0, "stall on misaligned request");
      checkFault(LSUHTRANS != htransIdle, 1'b0, "address phase on misaligned request");
    end else begin
      // Address phase in the request cycle
      checkFault(LSUHTRANS == htransNonseq, 1'b1, "address phase on request");
      checkAddr(LSUHADDR, r.adr, "bus address");
      checkFault(LSUHWRITE, r.rw == memWrite, "bus write flag");
      checkSize(LSUHSIZE, busSize(n), "bus size");
      while (LSUStallM) begin
        if (r.rw == memWrite) checkMask(LSUHWSTRB, expStrobe, "write strobe");
        @(negedge clk);
      end
      // Done cycle
      checkFault(LoadAccessFaultM, r.stuck && r.rw == memRead, "load access fault");
      checkFault(StoreAmoAccessFaultM, r.stuck && r.rw == memWrite, "store access fault");
      if (!r.stuck && r.rw == memWrite) storeShadow(r);
      if (!r.stuck && r.rw == memRead) lastRead = loadExpect(r);
    end
    @(posedge clk);
    #1;
    MemRWM = memNone;  // One idle cycle between rows
    stuck  = 1'b0;
    @(negedge clk);
    checkWord(ReadDataW, lastRead, $sformatf("ReadDataW after access to %h", r.adr));
  endtask

  initial begin
    int total;
    clk        = 1'b0;
    rst        = 1'b1;
    MemRWM     = memNone;
    Funct3M    = '0;
    IEUAdrM    = '0;
    WriteDataM = '0;
    BigEndianM = 1'b0;
    waitCycles = '0;
    stuck      = 1'b0;
    void'($urandom(32'hfdc720e8));
    fillTable();
    total = 0;
    foreach (stim[i]) begin
      if (stim[i].waits == randW) stim[i].waits = 8'($urandom % 12);
      total += int'(stim[i].waits) + 4;
    end
    cycleLimit = 4 * total + resetCycles;
    for (int i = 0; i < 16; i++) shadow[i] = fillWord(i);
    lastRead = '0;
    repeat (resetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (stim[i]) runRow(stim[i]);
    $display("Verification passed");
    $finish;
  end

endmodule

//--- list.f
source/lsuPkg.sv
source/busCtrl.sv
source/waitTimer.sv
source/storeFormat.sv
source/loadFormat.sv
source/lsu.sv
tb/memSlave.sv
tb/lsuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module lsuTb -f list.f -o lsuSim

./obj_dir/lsuSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
